// ==== phase_timer.sv ====
`timescale 1ns/10ps

module phase_timer
    import rope_video_pkg::*;
(
    input  logic   clk_core,
    input  logic   i_rst_n,
    input  logic   i_step,
    input  logic   i_restart,
    input  coord_t i_last_count,
    output coord_t o_count,
    output logic   o_done
);

    // ********************
    // position inside phase
    // ********************

    // count only moves on a step
    // restart wins over increment at the phase boundary
    always_ff @(posedge clk_core) begin
        if (!i_rst_n) begin
            o_count <= '0;
        end else if (i_step) begin
            if (i_restart) begin
                o_count <= '0;
            end else begin
                o_count <= o_count + coord_t'(1);
            end
        end
    end

    // last count of the phase reached
    // stays high until the next step moves on
    always_comb begin
        o_done = (o_count == i_last_count);
    end

endmodule

// ==== pixel_colorizer.sv ====
`timescale 1ns/10ps

module pixel_colorizer
    import rope_video_pkg::*;
(
    input  logic       clk_core,
    input  logic       i_rst_n,
    input  icon_e      i_icon,
    input  logic       i_video_on,
    input  logic       i_hsync_n,
    input  logic       i_vsync_n,
    output logic [3:0] o_red,
    output logic [3:0] o_grn,
    output logic [3:0] o_blu,
    output logic       o_video_on,
    output logic       o_hsync_n,
    output logic       o_vsync_n
);

    logic [11:0] pix_rgb;

    // sprite code to colour, black in blanking
    always_comb begin
        if (!i_video_on) begin
            pix_rgb = 12'h000;
        end else begin
            unique case (i_icon)
                ICON_ROPE:   pix_rgb = CLR_ROPE;
                ICON_KNOT:   pix_rgb = CLR_KNOT;
                ICON_CENTER: pix_rgb = CLR_CENTER;
                default:     pix_rgb = CLR_BG;
            endcase
        end
    end

    // ********************
    // colour and sync stage
    // ********************

    // syncs ride along so they stay aligned with colour
    always_ff @(posedge clk_core) begin
        if (!i_rst_n) begin
            o_red      <= 4'h0;
            o_grn      <= 4'h0;
            o_blu      <= 4'h0;
            o_video_on <= 1'b0;
            o_hsync_n  <= 1'b1;
            o_vsync_n  <= 1'b1;
        end else begin
            o_red      <= pix_rgb[11:8];
            o_grn      <= pix_rgb[7:4];
            o_blu      <= pix_rgb[3:0];
            o_video_on <= i_video_on;
            o_hsync_n  <= i_hsync_n;
            o_vsync_n  <= i_vsync_n;
        end
    end

endmodule

// ==== rope_renderer.sv ====
`timescale 1ns/10ps

module rope_renderer
    import rope_video_pkg::*;
(
    input  logic   clk_core,
    input  logic   i_rst_n,
    input  phase_e i_h_phase,
    input  phase_e i_v_phase,
    input  coord_t i_col,
    input  coord_t i_row,
    input  coord_t i_rope_loc,
    output icon_e  o_icon,
    output logic   o_video_on,
    output logic   o_hsync_n,
    output logic   o_vsync_n
);

    coord_t              rope_q;
    coord_t              rope_cur;
    logic                frame_start;
    logic                video_on;
    logic                in_band;
    logic                in_knot;
    logic [COORD_W:0]    col_plus;
    logic [COORD_W:0]    loc_plus;
    icon_e               icon;

    // ********************
    // frame-start latch
    // ********************

    // first active pixel of the frame
    assign frame_start = (i_h_phase == PH_ACTIVE) && (i_v_phase == PH_ACTIVE)
                         && (i_col == '0) && (i_row == '0);

    always_ff @(posedge clk_core) begin
        if (!i_rst_n) begin
            rope_q <= '0;
        end else if (frame_start) begin
            rope_q <= i_rope_loc;
        end
    end

    // pixel 0 already uses the value being latched
    assign rope_cur = frame_start ? i_rope_loc : rope_q;

    // ********************
    // sprite decode
    // ********************

    assign video_on = (i_h_phase == PH_ACTIVE) && (i_v_phase == PH_ACTIVE);
    assign in_band  = (i_row >= coord_t'(ROPE_TOP)) && (i_row <= coord_t'(ROPE_BOT));

    // one extra bit so col+8 and loc+8 never wrap
    assign col_plus = {1'b0, i_col} + (COORD_W+1)'(KNOT_HALF);
    assign loc_plus = {1'b0, rope_cur} + (COORD_W+1)'(KNOT_HALF);
    assign in_knot  = (col_plus > {1'b0, rope_cur}) && ({1'b0, i_col} < loc_plus);

    // knot over centre line over rope
    always_comb begin
        if (in_band && in_knot) begin
            icon = ICON_KNOT;
        end else if (i_col == coord_t'(CENTER_COL)) begin
            icon = ICON_CENTER;
        end else if (in_band) begin
            icon = ICON_ROPE;
        end else begin
            icon = ICON_NONE;
        end
    end

    // ********************
    // output stage
    // ********************

    // syncs idle high, active low in the sync phase
    always_ff @(posedge clk_core) begin
        if (!i_rst_n) begin
            o_icon     <= ICON_NONE;
            o_video_on <= 1'b0;
            o_hsync_n  <= 1'b1;
            o_vsync_n  <= 1'b1;
        end else begin
            o_icon     <= icon;
            o_video_on <= video_on;
            o_hsync_n  <= (i_h_phase != PH_SYNC);
            o_vsync_n  <= (i_v_phase != PH_SYNC);
        end
    end

endmodule

// ==== rope_video_pkg.sv ====
package rope_video_pkg;

    // ********************
    // 640x480 display timing
    // ********************

    // horizontal phase lengths, in pixels
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;

    // vertical phase lengths, in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;

    // positions, rope location and phase counts share this width
    localparam int COORD_W = 10;

    typedef logic [COORD_W-1:0] coord_t;

    // one timing axis walks through these in order
    typedef enum logic [1:0] {
        PH_ACTIVE = 2'd0,
        PH_FRONT  = 2'd1,
        PH_SYNC   = 2'd2,
        PH_BACK   = 2'd3
    } phase_e;

    // ********************
    // rope sprite geometry
    // ********************

    // sprite code per pixel
    typedef enum logic [1:0] {
        ICON_NONE   = 2'd0,
        ICON_ROPE   = 2'd1,
        ICON_KNOT   = 2'd2,
        ICON_CENTER = 2'd3
    } icon_e;

    // first and last row of the rope band
    localparam int ROPE_TOP   = 232;
    localparam int ROPE_BOT   = 247;
    localparam int KNOT_HALF  = 8;
    localparam int CENTER_COL = 320;

    // colours as {red, green, blue} nibbles
    localparam logic [11:0] CLR_BG     = 12'h030;
    localparam logic [11:0] CLR_ROPE   = 12'h852;
    localparam logic [11:0] CLR_KNOT   = 12'hF00;
    localparam logic [11:0] CLR_CENTER = 12'hFFF;

endpackage

// ==== rope_video_properties.sv ====
`timescale 1ns/10ps

module rope_video_properties
    import rope_video_pkg::*;
(
    input logic       clk_core,
    input logic       i_rst_n,
    input logic       i_hsync_n,
    input logic       i_vsync_n,
    input logic       i_video_on,
    input logic [3:0] i_red,
    input logic [3:0] i_grn,
    input logic [3:0] i_blu
);

    int low_len;

    // length of the running hsync low pulse
    always_ff @(posedge clk_core) begin
        if (!i_rst_n) begin
            low_len <= 0;
        end else if (!i_hsync_n) begin
            low_len <= low_len + 1;
        end else begin
            low_len <= 0;
        end
    end

    // ********************
    // output properties
    // ********************

    // no sync pulse inside the active area
    a_sync_idle_active: assert property (@(posedge clk_core) disable iff (!i_rst_n)
        i_video_on |-> (i_hsync_n && i_vsync_n))
        else $error("sync pulse while video is on");

    // blanking is black
    a_black_blanking: assert property (@(posedge clk_core) disable iff (!i_rst_n)
        !i_video_on |-> ({i_red, i_grn, i_blu} == 12'h000))
        else $error("colour output not black during blanking");

    // pulse just ended, check its width
    a_hsync_width: assert property (@(posedge clk_core) disable iff (!i_rst_n)
        $rose(i_hsync_n) |-> (low_len == H_SYNC))
        else $error("hsync low pulse lasted %0d cycles", low_len);

endmodule

bind rope_video_top rope_video_properties props0 (
    .clk_core   (clk_core),
    .i_rst_n    (i_rst_n),
    .i_hsync_n  (o_hsync_n),
    .i_vsync_n  (o_vsync_n),
    .i_video_on (o_video_on),
    .i_red      (o_red),
    .i_grn      (o_grn),
    .i_blu      (o_blu)
);

// ==== rope_video_top.f ====
rope_video_pkg.sv
phase_timer.sv
sync_phase_fsm.sv
rope_renderer.sv
pixel_colorizer.sv
rope_video_top.sv
rope_video_properties.sv
tb_rope_video.sv

// ==== rope_video_top.sv ====
`timescale 1ns/10ps

module rope_video_top
    import rope_video_pkg::*;
(
    input  logic       clk_core,
    input  logic       i_rst_n,
    input  coord_t     i_rope_loc,
    output logic       o_hsync_n,
    output logic       o_vsync_n,
    output logic       o_video_on,
    output logic [3:0] o_red,
    output logic [3:0] o_grn,
    output logic [3:0] o_blu
);

    phase_e h_phase;
    phase_e v_phase;
    coord_t col;
    coord_t row;
    logic   line_wrap;
    icon_e  icon;
    logic   rnd_video_on;
    logic   rnd_hsync_n;
    logic   rnd_vsync_n;

    // ********************
    // timing axes
    // ********************

    // one pixel per clock
    sync_phase_fsm #(
        .ACTIVE_LEN (H_ACTIVE),
        .FRONT_LEN  (H_FRONT),
        .SYNC_LEN   (H_SYNC),
        .BACK_LEN   (H_BACK)
    ) h_fsm (
        .clk_core (clk_core),
        .i_rst_n  (i_rst_n),
        .i_step   (1'b1),
        .o_phase  (h_phase),
        .o_pos    (col),
        .o_wrap   (line_wrap)
    );

    // one step per line, frame end not needed downstream
    sync_phase_fsm #(
        .ACTIVE_LEN (V_ACTIVE),
        .FRONT_LEN  (V_FRONT),
        .SYNC_LEN   (V_SYNC),
        .BACK_LEN   (V_BACK)
    ) v_fsm (
        .clk_core (clk_core),
        .i_rst_n  (i_rst_n),
        .i_step   (line_wrap),
        .o_phase  (v_phase),
        .o_pos    (row),
        .o_wrap   ()
    );

    // ********************
    // pixel pipeline
    // ********************

    rope_renderer render0 (
        .clk_core   (clk_core),
        .i_rst_n    (i_rst_n),
        .i_h_phase  (h_phase),
        .i_v_phase  (v_phase),
        .i_col      (col),
        .i_row      (row),
        .i_rope_loc (i_rope_loc),
        .o_icon     (icon),
        .o_video_on (rnd_video_on),
        .o_hsync_n  (rnd_hsync_n),
        .o_vsync_n  (rnd_vsync_n)
    );

    pixel_colorizer color0 (
        .clk_core   (clk_core),
        .i_rst_n    (i_rst_n),
        .i_icon     (icon),
        .i_video_on (rnd_video_on),
        .i_hsync_n  (rnd_hsync_n),
        .i_vsync_n  (rnd_vsync_n),
        .o_red      (o_red),
        .o_grn      (o_grn),
        .o_blu      (o_blu),
        .o_video_on (o_video_on),
        .o_hsync_n  (o_hsync_n),
        .o_vsync_n  (o_vsync_n)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the rope video testbench with Verilator and run it

LOG=sim_rope_video.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rope_video -f rope_video_top.f -o sim_rope_video \
    && ./obj_dir/sim_rope_video > "$LOG" 2>&1 \
    || echo "build or simulation exited with an error" >> "$LOG"

cat "$LOG"

grep -q "STATUS: FAIL" "$LOG" && { echo "simulation failed"; exit 1; }
grep -q "STATUS: PASS" "$LOG" || { echo "simulation gave no result"; exit 1; }
echo "simulation passed"

// ==== sync_phase_fsm.sv ====
`timescale 1ns/10ps

module sync_phase_fsm
    import rope_video_pkg::*;
#(
    parameter int ACTIVE_LEN = H_ACTIVE,
    parameter int FRONT_LEN  = H_FRONT,
    parameter int SYNC_LEN   = H_SYNC,
    parameter int BACK_LEN   = H_BACK
) (
    input  logic   clk_core,
    input  logic   i_rst_n,
    input  logic   i_step,
    output phase_e o_phase,
    output coord_t o_pos,
    output logic   o_wrap
);

    coord_t last_count;
    phase_e next_phase;
    logic   phase_done;
    logic   advance;

    // ********************
    // phase sequencing
    // ********************

    // last count and successor of the current phase
    always_comb begin
        unique case (o_phase)
            PH_ACTIVE: begin
                last_count = coord_t'(ACTIVE_LEN - 1);
                next_phase = PH_FRONT;
            end
            PH_FRONT: begin
                last_count = coord_t'(FRONT_LEN - 1);
                next_phase = PH_SYNC;
            end
            PH_SYNC: begin
                last_count = coord_t'(SYNC_LEN - 1);
                next_phase = PH_BACK;
            end
            default: begin
                last_count = coord_t'(BACK_LEN - 1);
                next_phase = PH_ACTIVE;
            end
        endcase
    end

    // leave the phase on its last count, but only on a step
    assign advance = phase_done & i_step;

    always_ff @(posedge clk_core) begin
        if (!i_rst_n) begin
            o_phase <= PH_ACTIVE;
        end else if (advance) begin
            o_phase <= next_phase;
        end
    end

    // timer doubles as the active-area position
    phase_timer timer0 (
        .clk_core     (clk_core),
        .i_rst_n      (i_rst_n),
        .i_step       (i_step),
        .i_restart    (advance),
        .i_last_count (last_count),
        .o_count      (o_pos),
        .o_done       (phase_done)
    );

    // end of the whole axis period
    assign o_wrap = advance & (o_phase == PH_BACK);

endmodule

// ==== tb_rope_video.sv ====
`timescale 1ns/10ps

module tb_rope_video
    import rope_video_pkg::*;
();

    localparam int SEED        = 32'h3d60;
    localparam int LINE_LEN    = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int FRAME_LINES = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_LEN   = LINE_LEN * FRAME_LINES;
    localparam int RUN_CYCLES  = 2 * FRAME_LEN + 100;
    // two frames of 420000 pixels plus margin
    localparam int TIMEOUT_CYC = 2 * 420000 + 1000;
    localparam int N_TESTS     = 6;

    // test indices
    localparam int T_RESET  = 0;
    localparam int T_HSYNC  = 1;
    localparam int T_VSYNC  = 2;
    localparam int T_BLANK  = 3;
    localparam int T_SPRITE = 4;
    localparam int T_LATCH  = 5;

    logic       clk_core;
    logic       i_rst_n;
    coord_t     i_rope_loc;
    logic       o_hsync_n;
    logic       o_vsync_n;
    logic       o_video_on;
    logic [3:0] o_red;
    logic [3:0] o_grn;
    logic [3:0] o_blu;

    int    check_cnt [N_TESTS];
    int    err_cnt [N_TESTS];
    string test_name [N_TESTS] = '{"reset", "hsync", "vsync", "blanking", "sprite", "latching"};
    // rope location sampled at each frame start
    int    frame_loc [4];
    int    next_change;
    // latched pixels whose knot would differ at the port value
    int    latch_hits;
    int    cur_pix;
    int    cycle_cnt = 0;

    // 4 ns period
    always #2 clk_core = ~clk_core;

    rope_video_top dut0 (
        .clk_core   (clk_core),
        .i_rst_n    (i_rst_n),
        .i_rope_loc (i_rope_loc),
        .o_hsync_n  (o_hsync_n),
        .o_vsync_n  (o_vsync_n),
        .o_video_on (o_video_on),
        .o_red      (o_red),
        .o_grn      (o_grn),
        .o_blu      (o_blu)
    );

    // ********************
    // checks and model
    // ********************

    task automatic check_value(input int t, input string sig, input logic [31:0] exp,
                               input logic [31:0] act);
        check_cnt[t]++;
        assert (exp == act) else begin
            err_cnt[t]++;
            $display("CHECK FAILED %s: expected 0x%0h, got 0x%0h at pixel %0d",
                     sig, exp, act, cur_pix);
        end
    endtask

    // idle levels while in reset and right after it
    task automatic check_idle();
        check_value(T_RESET, "o_hsync_n", 32'd1, 32'(o_hsync_n));
        check_value(T_RESET, "o_vsync_n", 32'd1, 32'(o_vsync_n));
        check_value(T_RESET, "o_video_on", 32'd0, 32'(o_video_on));
        check_value(T_RESET, "rgb", 32'd0, 32'({o_red, o_grn, o_blu}));
    endtask

    task automatic check_pixel(input int p);
        int          col;
        int          row;
        int          loc;
        logic        vid;
        logic        hs;
        logic        vs;
        logic        band;
        logic        knot;
        logic        knot_now;
        logic [11:0] rgb;
        cur_pix = p;
        col  = p % LINE_LEN;
        row  = (p / LINE_LEN) % FRAME_LINES;
        loc  = frame_loc[p / FRAME_LEN];
        vid  = (col < H_ACTIVE) && (row < V_ACTIVE);
        // sync low inside the sync phase only
        hs   = !((col >= H_ACTIVE + H_FRONT) && (col < H_ACTIVE + H_FRONT + H_SYNC));
        vs   = !((row >= V_ACTIVE + V_FRONT) && (row < V_ACTIVE + V_FRONT + V_SYNC));
        band = (row >= ROPE_TOP) && (row <= ROPE_BOT);
        knot = band && (col + KNOT_HALF > loc) && (col < loc + KNOT_HALF);
        // knot over centre over rope over background
        if (knot)
            rgb = CLR_KNOT;
        else if (col == CENTER_COL)
            rgb = CLR_CENTER;
        else if (band)
            rgb = CLR_ROPE;
        else
            rgb = CLR_BG;
        check_value(T_HSYNC, "o_hsync_n", 32'(hs), 32'(o_hsync_n));
        check_value(T_VSYNC, "o_vsync_n", 32'(vs), 32'(o_vsync_n));
        check_value(T_BLANK, "o_video_on", 32'(vid), 32'(o_video_on));
        if (!vid) begin
            check_value(T_BLANK, "rgb", 32'd0, 32'({o_red, o_grn, o_blu}));
        end else if (band && loc != int'(i_rope_loc)) begin
            // port already moved on, knot must stay put
            knot_now = (col + KNOT_HALF > int'(i_rope_loc))
                       && (col < int'(i_rope_loc) + KNOT_HALF);
            if (knot_now != knot)
                latch_hits++;
            check_value(T_LATCH, "rgb", 32'(rgb), 32'({o_red, o_grn, o_blu}));
        end else begin
            check_value(T_SPRITE, "rgb", 32'(rgb), 32'({o_red, o_grn, o_blu}));
        end
    endtask

    // new rope location at random gaps, sampled for pixel p
    task automatic drive_rope(input int p);
        if (p >= next_change) begin
            i_rope_loc  = coord_t'($urandom % 800);
            next_change = p + int'($urandom % 5000) + 1;
        end
        if (p % FRAME_LEN == 0)
            frame_loc[p / FRAME_LEN] = int'(i_rope_loc);
    endtask

    task automatic print_test(input int t);
        $display("test %s done: %0d checks, %0d errors", test_name[t], check_cnt[t], err_cnt[t]);
    endtask

    // ********************
    // run
    // ********************

    initial begin
        int total_checks;
        int total_errs;
        void'($urandom(SEED));
        clk_core    = 1'b0;
        i_rst_n     = 1'b0;
        i_rope_loc  = '0;
        next_change = 0;
        latch_hits  = 0;
        cur_pix     = -1;
        foreach (check_cnt[i]) begin
            check_cnt[i] = 0;
            err_cnt[i]   = 0;
        end
        repeat (5) begin
            @(negedge clk_core);
            check_idle();
        end
        i_rst_n = 1'b1;
        drive_rope(0);
        // after the m-th edge out of reset the outputs show pixel m-2
        for (int m = 1; m <= RUN_CYCLES + 1; m++) begin
            @(negedge clk_core);
            if (m == 1) begin
                check_idle();
                print_test(T_RESET);
            end else begin
                check_pixel(m - 2);
            end
            drive_rope(m);
        end
        assert (latch_hits > 0) else begin
            err_cnt[T_LATCH]++;
            $display("no mid-frame rope change ever moved the knot off the latched location");
        end
        for (int t = 1; t < N_TESTS; t++)
            print_test(t);
        total_checks = 0;
        total_errs   = 0;
        foreach (err_cnt[t]) begin
            total_checks += check_cnt[t];
            total_errs   += err_cnt[t];
        end
        $display("total: %0d checks, %0d errors", total_checks, total_errs);
        if (total_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // guard against a stuck run
    always @(posedge clk_core) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("STATUS: FAIL");
            $finish;
        end
    end

endmodule
